//--- alu_pkg.sv
// rv64 alu shared definitions
package alu_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  alu_op_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD    = 5'b00000;
  localparam alu_op_t ALU_SUB    = 5'b00001;
  localparam alu_op_t ALU_SLT    = 5'b00010;
  localparam alu_op_t ALU_SLTU   = 5'b00011;
  localparam alu_op_t ALU_XOR    = 5'b00100;
  localparam alu_op_t ALU_AND    = 5'b00101;
  localparam alu_op_t ALU_OR     = 5'b00110;
  localparam alu_op_t ALU_SLL    = 5'b00111;
  localparam alu_op_t ALU_SRL    = 5'b01000;
  localparam alu_op_t ALU_SRA    = 5'b01001;
  localparam alu_op_t ALU_MUL    = 5'b01010;
  localparam alu_op_t ALU_DIV    = 5'b01011;
  localparam alu_op_t ALU_DIVU   = 5'b01100;
  localparam alu_op_t ALU_REM    = 5'b01101;
  localparam alu_op_t ALU_REMU   = 5'b01110;
  localparam alu_op_t ALU_COPY   = 5'b01111;
  localparam alu_op_t ALU_MULH   = 5'b11001;
  localparam alu_op_t ALU_MULHSU = 5'b11010;
  localparam alu_op_t ALU_MULHU  = 5'b11011;

  // major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;

  // apb register map
  localparam apb_addr_t REG_A_LO   = 8'h00;
  localparam apb_addr_t REG_A_HI   = 8'h04;
  localparam apb_addr_t REG_B_LO   = 8'h08;
  localparam apb_addr_t REG_B_HI   = 8'h0C;
  localparam apb_addr_t REG_INSTR  = 8'h10;
  localparam apb_addr_t REG_STATUS = 8'h14;
  localparam apb_addr_t REG_RES_LO = 8'h18;
  localparam apb_addr_t REG_RES_HI = 8'h1C;

  // status register bits
  localparam int STATUS_BUSY_BIT    = 0;
  localparam int STATUS_DONE_BIT    = 1;
  localparam int STATUS_ILLEGAL_BIT = 2;

endpackage

//--- alu_apb_regs.sv
// alu apb register block
module alu_apb_regs (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  alu_pkg::apb_addr_t i_paddr,
  input  alu_pkg::apb_data_t i_pwdata,
  output alu_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  input  logic               i_done,
  input  logic               i_illegal,
  input  alu_pkg::word_t     i_result,
  output logic               o_start,
  output alu_pkg::instr_t    o_instr,
  output alu_pkg::word_t     o_src_a,
  output alu_pkg::word_t     o_src_b
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t             state_q;
  logic               access;
  logic               wr_en;
  logic               addr_hit;
  logic               instr_hit;
  logic               launch;
  logic               done_q;
  logic               illegal_q;
  alu_pkg::word_t     result_q;
  alu_pkg::apb_data_t status;

  assign access    = i_psel & i_penable;
  assign wr_en     = access & i_pwrite;
  assign instr_hit = wr_en & (i_paddr == alu_pkg::REG_INSTR);
  assign launch    = instr_hit & (state_q == ST_IDLE);

  // no wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = (access & ~addr_hit) | (instr_hit & (state_q == ST_BUSY));

  always_comb begin
    status = '0;
    status[alu_pkg::STATUS_BUSY_BIT]    = (state_q == ST_BUSY);
    status[alu_pkg::STATUS_DONE_BIT]    = done_q;
    status[alu_pkg::STATUS_ILLEGAL_BIT] = illegal_q;
  end

  // read mux and address decode
  always_comb begin
    addr_hit = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      alu_pkg::REG_A_LO:   o_prdata = o_src_a[31:0];
      alu_pkg::REG_A_HI:   o_prdata = o_src_a[63:32];
      alu_pkg::REG_B_LO:   o_prdata = o_src_b[31:0];
      alu_pkg::REG_B_HI:   o_prdata = o_src_b[63:32];
      alu_pkg::REG_INSTR:  o_prdata = o_instr;
      alu_pkg::REG_STATUS: o_prdata = status;
      alu_pkg::REG_RES_LO: o_prdata = result_q[31:0];
      alu_pkg::REG_RES_HI: o_prdata = result_q[63:32];
      default:             addr_hit = 1'b0;
    endcase
  end

  // operand and instruction registers
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      case (i_paddr)
        alu_pkg::REG_A_LO: o_src_a[31:0]  <= i_pwdata;
        alu_pkg::REG_A_HI: o_src_a[63:32] <= i_pwdata;
        alu_pkg::REG_B_LO: o_src_b[31:0]  <= i_pwdata;
        alu_pkg::REG_B_HI: o_src_b[63:32] <= i_pwdata;
        default: ;
      endcase
    end
    if (launch) begin
      o_instr <= i_pwdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q   <= ST_IDLE;
      o_start   <= 1'b0;
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      result_q  <= '0;
    end else begin
      o_start <= launch;
      case (state_q)
        ST_IDLE: if (launch) state_q <= ST_BUSY;
        ST_BUSY: if (i_done) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
      // done holds until the next launch
      if (launch) begin
        done_q <= 1'b0;
      end else if (i_done) begin
        done_q <= 1'b1;
      end
      if (i_done) begin
        result_q  <= i_result;
        illegal_q <= i_illegal;
      end
    end
  end

endmodule

//--- alu_decode.sv
// rv64 instruction decoder
module alu_decode (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_start,
  input  alu_pkg::instr_t  i_instr,
  input  alu_pkg::word_t   i_src_a,
  input  alu_pkg::word_t   i_src_b,
  output logic             o_valid,
  output alu_pkg::alu_op_t o_alu_op,
  output logic             o_word_cut,
  output alu_pkg::word_t   o_src_a,
  output alu_pkg::word_t   o_src_b,
  output logic             o_illegal
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  alu_pkg::word_t   imm_i;
  alu_pkg::word_t   imm_u;
  alu_pkg::alu_op_t op_d;
  alu_pkg::word_t   src_b_d;
  logic             word_d;
  logic             illegal_d;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign imm_i  = alu_pkg::word_t'($signed(i_instr[31:20]));
  assign imm_u  = alu_pkg::word_t'($signed({i_instr[31:12], 12'h000}));

  always_comb begin
    op_d      = alu_pkg::ALU_ADD;
    word_d    = 1'b0;
    illegal_d = 1'b0;
    src_b_d   = i_src_b;
    case (opcode)
      alu_pkg::OPC_OP, alu_pkg::OPC_OP_32: begin
        word_d = (opcode == alu_pkg::OPC_OP_32);
        case (funct7)
          7'b0000000: begin
            case (funct3)
              3'd0:    op_d = alu_pkg::ALU_ADD;
              3'd1:    op_d = alu_pkg::ALU_SLL;
              3'd2:    op_d = alu_pkg::ALU_SLT;
              3'd3:    op_d = alu_pkg::ALU_SLTU;
              3'd4:    op_d = alu_pkg::ALU_XOR;
              3'd5:    op_d = alu_pkg::ALU_SRL;
              3'd6:    op_d = alu_pkg::ALU_OR;
              default: op_d = alu_pkg::ALU_AND;
            endcase
            illegal_d = word_d && !(funct3 inside {3'd0, 3'd1, 3'd5});
          end
          7'b0100000: begin
            op_d      = (funct3 == 3'd5) ? alu_pkg::ALU_SRA : alu_pkg::ALU_SUB;
            illegal_d = !(funct3 inside {3'd0, 3'd5});
          end
          7'b0000001: begin
            case (funct3)
              3'd0:    op_d = alu_pkg::ALU_MUL;
              3'd1:    op_d = alu_pkg::ALU_MULH;
              3'd2:    op_d = alu_pkg::ALU_MULHSU;
              3'd3:    op_d = alu_pkg::ALU_MULHU;
              3'd4:    op_d = alu_pkg::ALU_DIV;
              3'd5:    op_d = alu_pkg::ALU_DIVU;
              3'd6:    op_d = alu_pkg::ALU_REM;
              default: op_d = alu_pkg::ALU_REMU;
            endcase
            // no mulh variants in the word forms
            illegal_d = word_d && (funct3 inside {3'd1, 3'd2, 3'd3});
          end
          default: illegal_d = 1'b1;
        endcase
      end
      alu_pkg::OPC_OP_IMM, alu_pkg::OPC_OP_IMM_32: begin
        word_d  = (opcode == alu_pkg::OPC_OP_IMM_32);
        src_b_d = imm_i;
        case (funct3)
          3'd0: op_d = alu_pkg::ALU_ADD;
          3'd1: begin
            op_d      = alu_pkg::ALU_SLL;
            illegal_d = (funct7[6:1] != 6'b000000) || (word_d && funct7[0]);
          end
          3'd2: op_d = alu_pkg::ALU_SLT;
          3'd3: op_d = alu_pkg::ALU_SLTU;
          3'd4: op_d = alu_pkg::ALU_XOR;
          3'd5: begin
            op_d      = funct7[5] ? alu_pkg::ALU_SRA : alu_pkg::ALU_SRL;
            illegal_d = !(funct7[6:1] inside {6'b000000, 6'b010000}) || (word_d && funct7[0]);
          end
          3'd6: op_d = alu_pkg::ALU_OR;
          default: op_d = alu_pkg::ALU_AND;
        endcase
        // only addiw and the shifts exist as word immediates
        if (word_d && !(funct3 inside {3'd0, 3'd1, 3'd5})) begin
          illegal_d = 1'b1;
        end
      end
      alu_pkg::OPC_LUI: begin
        op_d    = alu_pkg::ALU_COPY;
        src_b_d = imm_u;
      end
      default: illegal_d = 1'b1;
    endcase
    if (illegal_d) begin
      op_d   = alu_pkg::ALU_ADD;
      word_d = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_start;
      o_illegal <= i_start & illegal_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_alu_op   <= op_d;
      o_word_cut <= word_d;
      o_src_a    <= i_src_a;
      o_src_b    <= src_b_d;
    end
  end

endmodule

//--- alu_execute.sv
// rv64 integer alu
module alu_execute #(
  parameter int WORD_WD = 64
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_valid,
  input  alu_pkg::alu_op_t   i_alu_op,
  input  logic               i_word_cut,
  input  logic [WORD_WD-1:0] i_src_a,
  input  logic [WORD_WD-1:0] i_src_b,
  input  logic               i_illegal,
  output logic               o_valid,
  output logic [WORD_WD-1:0] o_raw_result,
  output logic               o_word_cut,
  output logic               o_illegal
);

  localparam int SH_WD = $clog2(WORD_WD);

  typedef logic [WORD_WD-1:0]   data_t;
  typedef logic [2*WORD_WD-1:0] wide_t;

  data_t            a_sx;
  data_t            b_sx;
  data_t            a_zx;
  data_t            b_zx;
  data_t            sign_min;
  logic [SH_WD-1:0] shamt;
  wide_t            prod_ss;
  wide_t            prod_su;
  wide_t            prod_uu;
  logic             div_zero;
  logic             div_ovf;
  data_t            quo_s;
  data_t            quo_u;
  data_t            rem_s;
  data_t            rem_u;
  data_t            result_d;

  // word forms work on the low 32 bits
  assign a_sx  = i_word_cut ? data_t'($signed(i_src_a[31:0])) : i_src_a;
  assign b_sx  = i_word_cut ? data_t'($signed(i_src_b[31:0])) : i_src_b;
  assign a_zx  = i_word_cut ? data_t'(i_src_a[31:0]) : i_src_a;
  assign b_zx  = i_word_cut ? data_t'(i_src_b[31:0]) : i_src_b;
  assign shamt = i_word_cut ? SH_WD'(i_src_b[4:0]) : i_src_b[SH_WD-1:0];

  // double width products for the high halves
  assign prod_ss = wide_t'($signed(i_src_a)) * wide_t'($signed(i_src_b));
  assign prod_su = wide_t'($signed(i_src_a)) * wide_t'(i_src_b);
  assign prod_uu = wide_t'(i_src_a) * wide_t'(i_src_b);

  assign sign_min = i_word_cut ? data_t'($signed(32'h8000_0000))
                               : {1'b1, {(WORD_WD-1){1'b0}}};
  assign div_zero = (b_zx == '0);
  assign div_ovf  = (a_sx == sign_min) && (b_sx == '1);

  // divide by zero gives all ones, remainder keeps the dividend
  assign quo_s = div_zero ? '1 : div_ovf ? a_sx : data_t'($signed(a_sx) / $signed(b_sx));
  assign rem_s = div_zero ? a_sx : div_ovf ? '0 : data_t'($signed(a_sx) % $signed(b_sx));
  assign quo_u = div_zero ? '1 : a_zx / b_zx;
  assign rem_u = div_zero ? a_zx : a_zx % b_zx;

  always_comb begin
    case (i_alu_op)
      alu_pkg::ALU_COPY:   result_d = i_src_b;
      alu_pkg::ALU_ADD:    result_d = i_src_a + i_src_b;
      alu_pkg::ALU_SUB:    result_d = i_src_a - i_src_b;
      alu_pkg::ALU_SLT:    result_d = data_t'($signed(i_src_a) < $signed(i_src_b));
      alu_pkg::ALU_SLTU:   result_d = data_t'(i_src_a < i_src_b);
      alu_pkg::ALU_XOR:    result_d = i_src_a ^ i_src_b;
      alu_pkg::ALU_AND:    result_d = i_src_a & i_src_b;
      alu_pkg::ALU_OR:     result_d = i_src_a | i_src_b;
      alu_pkg::ALU_SLL:    result_d = i_src_a << shamt;
      alu_pkg::ALU_SRL:    result_d = a_zx >> shamt;
      alu_pkg::ALU_SRA:    result_d = data_t'($signed(a_sx) >>> shamt);
      alu_pkg::ALU_MUL:    result_d = prod_uu[WORD_WD-1:0];
      alu_pkg::ALU_MULH:   result_d = prod_ss[2*WORD_WD-1:WORD_WD];
      alu_pkg::ALU_MULHSU: result_d = prod_su[2*WORD_WD-1:WORD_WD];
      alu_pkg::ALU_MULHU:  result_d = prod_uu[2*WORD_WD-1:WORD_WD];
      alu_pkg::ALU_DIV:    result_d = quo_s;
      alu_pkg::ALU_DIVU:   result_d = quo_u;
      alu_pkg::ALU_REM:    result_d = rem_s;
      alu_pkg::ALU_REMU:   result_d = rem_u;
      default:             result_d = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_illegal <= i_valid & i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_raw_result <= result_d;
      o_word_cut   <= i_word_cut;
    end
  end

endmodule

//--- alu_result.sv
// alu result stage
module alu_result #(
  parameter int WORD_WD = 64
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_valid,
  input  logic [WORD_WD-1:0] i_raw_result,
  input  logic               i_word_cut,
  input  logic               i_illegal,
  output logic               o_done,
  output logic [WORD_WD-1:0] o_result,
  output logic               o_illegal
);

  logic [WORD_WD-1:0] result_d;

  // word ops extend bit 31, illegal ones return zero
  assign result_d = i_illegal  ? '0 :
                    i_word_cut ? (WORD_WD)'($signed(i_raw_result[31:0])) :
                    i_raw_result;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_done    <= 1'b0;
      o_result  <= '0;
      o_illegal <= 1'b0;
    end else begin
      o_done <= i_valid;
      if (i_valid) begin
        o_result  <= result_d;
        o_illegal <= i_illegal;
      end
    end
  end

endmodule

//--- alu_top.sv
// apb alu accelerator top
module alu_top (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  alu_pkg::apb_addr_t i_paddr,
  input  alu_pkg::apb_data_t i_pwdata,
  output alu_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr
);

  localparam int WORD_WD = 64;

  logic             start;
  alu_pkg::instr_t  instr;
  alu_pkg::word_t   reg_src_a;
  alu_pkg::word_t   reg_src_b;
  logic             dec_valid;
  alu_pkg::alu_op_t dec_alu_op;
  logic             dec_word_cut;
  alu_pkg::word_t   dec_src_a;
  alu_pkg::word_t   dec_src_b;
  logic             dec_illegal;
  logic             exe_valid;
  alu_pkg::word_t   exe_raw_result;
  logic             exe_word_cut;
  logic             exe_illegal;
  logic             res_done;
  alu_pkg::word_t   res_result;
  logic             res_illegal;

  alu_apb_regs u_regs (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_psel   (i_psel),
    .i_penable(i_penable),
    .i_pwrite (i_pwrite),
    .i_paddr  (i_paddr),
    .i_pwdata (i_pwdata),
    .o_prdata (o_prdata),
    .o_pready (o_pready),
    .o_pslverr(o_pslverr),
    .i_done   (res_done),
    .i_illegal(res_illegal),
    .i_result (res_result),
    .o_start  (start),
    .o_instr  (instr),
    .o_src_a  (reg_src_a),
    .o_src_b  (reg_src_b)
  );

  alu_decode u_decode (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_start   (start),
    .i_instr   (instr),
    .i_src_a   (reg_src_a),
    .i_src_b   (reg_src_b),
    .o_valid   (dec_valid),
    .o_alu_op  (dec_alu_op),
    .o_word_cut(dec_word_cut),
    .o_src_a   (dec_src_a),
    .o_src_b   (dec_src_b),
    .o_illegal (dec_illegal)
  );

  alu_execute #(
    .WORD_WD(WORD_WD)
  ) u_execute (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_valid     (dec_valid),
    .i_alu_op    (dec_alu_op),
    .i_word_cut  (dec_word_cut),
    .i_src_a     (dec_src_a),
    .i_src_b     (dec_src_b),
    .i_illegal   (dec_illegal),
    .o_valid     (exe_valid),
    .o_raw_result(exe_raw_result),
    .o_word_cut  (exe_word_cut),
    .o_illegal   (exe_illegal)
  );

  alu_result #(
    .WORD_WD(WORD_WD)
  ) u_result (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_valid     (exe_valid),
    .i_raw_result(exe_raw_result),
    .i_word_cut  (exe_word_cut),
    .i_illegal   (exe_illegal),
    .o_done      (res_done),
    .o_result    (res_result),
    .o_illegal   (res_illegal)
  );

endmodule

//--- alu_top_checker.sv
// apb and pipeline timing checks
module alu_top_checker (
  input logic       i_clk,
  input logic       i_reset,
  input logic       i_psel,
  input logic       i_penable,
  input logic       i_pwrite,
  input logic [7:0] i_paddr,
  input logic       o_pready,
  input logic       o_pslverr,
  input logic       i_done
);
  timeunit 1ns;
  timeprecision 1ps;

  logic instr_ok;

  // accepted launch of a new instruction
  assign instr_ok = i_psel & i_penable & i_pwrite & ~o_pslverr &
                    (i_paddr == alu_pkg::REG_INSTR);

  pready_high: assert property (@(posedge i_clk) disable iff (i_reset) o_pready)
    else $error("pready dropped low");

  pslverr_in_access: assert property (@(posedge i_clk) disable iff (i_reset)
    o_pslverr |-> (i_psel & i_penable))
    else $error("pslverr outside an access phase");

  // done register loads on the fourth edge after the access phase
  done_latency: assert property (@(posedge i_clk) disable iff (i_reset)
    instr_ok |=> !i_done [*3] ##1 i_done)
    else $error("done bit not set four cycles after the instruction write");

endmodule

//--- alu_top_tb.sv
// alu accelerator testbench
module alu_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp;
    logic        ill;
  } row_t;

  localparam int NUM_RANDOM = 12;
  localparam int RESET_CYCLES = 10;

  logic        i_clk;
  logic        i_reset;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [7:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;

  row_t rows[$];
  logic rows_ready;
  int   pass_cnt;
  int   fail_cnt;

  alu_top i_dut (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_psel   (i_psel),
    .i_penable(i_penable),
    .i_pwrite (i_pwrite),
    .i_paddr  (i_paddr),
    .i_pwdata (i_pwdata),
    .o_prdata (o_prdata),
    .o_pready (o_pready),
    .o_pslverr(o_pslverr)
  );

  bind alu_top alu_top_checker u_checker (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_psel   (i_psel),
    .i_penable(i_penable),
    .i_pwrite (i_pwrite),
    .i_paddr  (i_paddr),
    .o_pready (o_pready),
    .o_pslverr(o_pslverr),
    .i_done   (res_done)
  );

  always #50 i_clk = ~i_clk;

  // rd x1, rs1 x2, rs2 x3
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
    return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
    return {imm, 5'd2, f3, 5'd1, opc};
  endfunction

  // behavioral rv64im model
  function automatic void model_result(input logic [31:0] ins, input logic [63:0] a,
                                       input logic [63:0] b_in, output logic [63:0] y,
                                       output logic ill);
    logic [6:0]         opc;
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic               w;
    logic               is_imm;
    logic               mext;
    logic               alt;
    logic [63:0]        b;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        mn;
    logic [5:0]         sh;
    logic [127:0]       p;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    y   = '0;
    ill = 1'b0;
    if (opc == alu_pkg::OPC_LUI) begin
      y = {{32{ins[31]}}, ins[31:12], 12'h000};
      return;
    end
    is_imm = (opc == alu_pkg::OPC_OP_IMM) || (opc == alu_pkg::OPC_OP_IMM_32);
    w      = (opc == alu_pkg::OPC_OP_32) || (opc == alu_pkg::OPC_OP_IMM_32);
    if (!is_imm && opc != alu_pkg::OPC_OP && opc != alu_pkg::OPC_OP_32) begin
      ill = 1'b1;
      return;
    end
    b    = is_imm ? {{52{ins[31]}}, ins[31:20]} : b_in;
    mext = !is_imm && (f7 == 7'h01);
    alt  = is_imm ? (f3 == 3'd5 && ins[30]) : (f7 == 7'h20);
    if (is_imm) begin
      if (f3 == 3'd1) ill = (ins[31:26] != 6'h00);
      if (f3 == 3'd5) ill = (ins[31:26] != 6'h00) && (ins[31:26] != 6'h10);
      if (w && (f3 == 3'd1 || f3 == 3'd5) && ins[25]) ill = 1'b1;
      if (w && !(f3 inside {3'd0, 3'd1, 3'd5})) ill = 1'b1;
    end else begin
      if (!(f7 inside {7'h00, 7'h20, 7'h01})) ill = 1'b1;
      if (f7 == 7'h20 && !(f3 inside {3'd0, 3'd5})) ill = 1'b1;
      if (w && !mext && !(f3 inside {3'd0, 3'd1, 3'd5})) ill = 1'b1;
      if (w && mext && (f3 inside {3'd1, 3'd2, 3'd3})) ill = 1'b1;
    end
    if (ill) return;
    sa = w ? {{32{a[31]}}, a[31:0]} : a;
    sb = w ? {{32{b[31]}}, b[31:0]} : b;
    ua = w ? {32'h0, a[31:0]} : a;
    ub = w ? {32'h0, b[31:0]} : b;
    sh = w ? {1'b0, b[4:0]} : b[5:0];
    mn = w ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    if (mext) begin
      case (f3)
        3'd0: y = a * b;
        3'd1: begin
          p = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
          y = p[127:64];
        end
        3'd2: begin
          p = $signed({{64{a[63]}}, a}) * $signed({64'h0, b});
          y = p[127:64];
        end
        3'd3: begin
          p = {64'h0, a} * {64'h0, b};
          y = p[127:64];
        end
        3'd4: begin
          if (ub == 0) y = '1;
          else if (sa == mn && sb == -1) y = sa;
          else y = sa / sb;
        end
        3'd5: y = (ub == 0) ? '1 : ua / ub;
        3'd6: begin
          if (ub == 0) y = sa;
          else if (sa == mn && sb == -1) y = '0;
          else y = sa % sb;
        end
        default: y = (ub == 0) ? ua : ua % ub;
      endcase
    end else begin
      case (f3)
        3'd0: y = alt ? a - b : a + b;
        3'd1: y = a << sh;
        3'd2: y = {63'h0, sa < sb};
        3'd3: y = {63'h0, ua < ub};
        3'd4: y = a ^ b;
        3'd5: begin
          if (alt) y = sa >>> sh;
          else y = ua >> sh;
        end
        3'd6: y = a | b;
        default: y = a & b;
      endcase
    end
    if (w) y = {{32{y[31]}}, y[31:0]};
  endfunction

  function automatic void add_row(input logic [31:0] ins, input logic [63:0] a,
                                  input logic [63:0] b, input logic [63:0] exp,
                                  input logic ill);
    row_t r;
    r.ins = ins;
    r.a   = a;
    r.b   = b;
    r.exp = exp;
    r.ill = ill;
    rows.push_back(r);
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge i_clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b1;
    i_paddr   = addr;
    i_pwdata  = data;
    @(negedge i_clk);
    i_penable = 1'b1;
    #10;
    err = o_pslverr;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge i_clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = addr;
    @(negedge i_clk);
    i_penable = 1'b1;
    #10;
    data = o_prdata;
    err  = o_pslverr;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic wait_done(output logic [31:0] st);
    logic err;
    do begin
      read_reg(alu_pkg::REG_STATUS, st, err);
    end while (!st[alu_pkg::STATUS_DONE_BIT]);
  endtask

  task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
    logic err;
    write_reg(alu_pkg::REG_A_LO, a[31:0], err);
    write_reg(alu_pkg::REG_A_HI, a[63:32], err);
    write_reg(alu_pkg::REG_B_LO, b[31:0], err);
    write_reg(alu_pkg::REG_B_HI, b[63:32], err);
  endtask

  task automatic read_result(output logic [63:0] res);
    logic err;
    read_reg(alu_pkg::REG_RES_LO, res[31:0], err);
    read_reg(alu_pkg::REG_RES_HI, res[63:32], err);
  endtask

  task automatic run_row(input int idx, input row_t r);
    logic [31:0] st;
    logic [63:0] res;
    logic        err;
    logic        bad;
    bad = 1'b0;
    load_operands(r.a, r.b);
    write_reg(alu_pkg::REG_INSTR, r.ins, err);
    wait_done(st);
    read_result(res);
    assert (res == r.exp) else begin
      $display("[FAIL] row %0d result exp %h got %h", idx, r.exp, res);
      bad = 1'b1;
    end
    assert (st[alu_pkg::STATUS_ILLEGAL_BIT] == r.ill) else begin
      $display("[FAIL] row %0d illegal exp %h got %h", idx, r.ill,
               st[alu_pkg::STATUS_ILLEGAL_BIT]);
      bad = 1'b1;
    end
    $display("row %0d instr %h: %s", idx, r.ins, bad ? "failed" : "ok");
    if (bad) fail_cnt++;
    else pass_cnt++;
  endtask

  task automatic check_protocol();
    logic [31:0] d;
    logic [31:0] st;
    logic [63:0] res;
    logic        err;
    logic        bad;
    bad = 1'b0;
    read_reg(8'h20, d, err);
    assert (err) else begin
      $display("unmapped address 0x20 did not return pslverr");
      bad = 1'b1;
    end
    load_operands(64'h9abc_def0_1234_5678, 64'h0000_0001_0000_0003);
    read_reg(alu_pkg::REG_A_LO, d, err);
    assert (d == 32'h1234_5678) else begin
      $display("[FAIL] prdata A_LO exp %h got %h", 32'h1234_5678, d);
      bad = 1'b1;
    end
    read_reg(alu_pkg::REG_A_HI, d, err);
    assert (d == 32'h9abc_def0) else begin
      $display("[FAIL] prdata A_HI exp %h got %h", 32'h9abc_def0, d);
      bad = 1'b1;
    end
    read_reg(alu_pkg::REG_B_LO, d, err);
    assert (d == 32'h0000_0003) else begin
      $display("[FAIL] prdata B_LO exp %h got %h", 32'h0000_0003, d);
      bad = 1'b1;
    end
    read_reg(alu_pkg::REG_B_HI, d, err);
    assert (d == 32'h0000_0001) else begin
      $display("[FAIL] prdata B_HI exp %h got %h", 32'h0000_0001, d);
      bad = 1'b1;
    end
    // second launch lands while the first is busy
    write_reg(alu_pkg::REG_INSTR, encode_r(7'h00, 3'd0, alu_pkg::OPC_OP), err);
    write_reg(alu_pkg::REG_INSTR, encode_r(7'h20, 3'd0, alu_pkg::OPC_OP), err);
    assert (err) else begin
      $display("instruction write while busy did not return pslverr");
      bad = 1'b1;
    end
    wait_done(st);
    read_result(res);
    assert (res == 64'h9abc_def1_1234_567b) else begin
      $display("[FAIL] result exp %h got %h", 64'h9abc_def1_1234_567b, res);
      bad = 1'b1;
    end
    $display("apb protocol: %s", bad ? "failed" : "ok");
    if (bad) fail_cnt++;
    else pass_cnt++;
  endtask

  task automatic build_table();
    logic [31:0] ops[$];
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] y;
    logic        ill;
    // alu, compare and logic
    add_row(encode_r(7'h00, 3'd0, alu_pkg::OPC_OP), 64'd5, 64'd7, 64'd12, 1'b0);
    add_row(encode_r(7'h20, 3'd0, alu_pkg::OPC_OP), 64'd5, 64'd7, '1 - 64'd1, 1'b0);
    add_row(encode_r(7'h00, 3'd2, alu_pkg::OPC_OP), '1, 64'd1, 64'd1, 1'b0);
    add_row(encode_r(7'h00, 3'd3, alu_pkg::OPC_OP), '1, 64'd1, 64'd0, 1'b0);
    add_row(encode_r(7'h00, 3'd4, alu_pkg::OPC_OP), 64'hf0f0, 64'hff00, 64'h0ff0, 1'b0);
    add_row(encode_r(7'h00, 3'd6, alu_pkg::OPC_OP), 64'hf0f0, 64'hff00, 64'hfff0, 1'b0);
    add_row(encode_r(7'h00, 3'd7, alu_pkg::OPC_OP), 64'hf0f0, 64'hff00, 64'hf000, 1'b0);
    add_row(encode_i(12'hfff, 3'd0, alu_pkg::OPC_OP_IMM), 64'd10, 64'd0, 64'd9, 1'b0);
    add_row(encode_i(12'h003, 3'd2, alu_pkg::OPC_OP_IMM), -64'sd5, 64'd0, 64'd1, 1'b0);
    add_row(encode_i(12'hfff, 3'd3, alu_pkg::OPC_OP_IMM), 64'd5, 64'd0, 64'd1, 1'b0);
    add_row(encode_i(12'h0f0, 3'd4, alu_pkg::OPC_OP_IMM), 64'hff, 64'd0, 64'h0f, 1'b0);
    add_row(encode_i(12'h0ff, 3'd6, alu_pkg::OPC_OP_IMM), 64'h100, 64'd0, 64'h1ff, 1'b0);
    add_row(encode_i(12'h0f0, 3'd7, alu_pkg::OPC_OP_IMM), 64'hfff, 64'd0, 64'hf0, 1'b0);
    // shifts
    add_row(encode_r(7'h00, 3'd1, alu_pkg::OPC_OP), 64'd1, 64'd63, 64'h8000_0000_0000_0000, 1'b0);
    add_row(encode_r(7'h00, 3'd5, alu_pkg::OPC_OP), 64'h8000_0000_0000_0000, 64'd63, 64'd1, 1'b0);
    add_row(encode_r(7'h20, 3'd5, alu_pkg::OPC_OP), 64'h8000_0000_0000_0000, 64'd63, '1, 1'b0);
    add_row(encode_i(12'h028, 3'd1, alu_pkg::OPC_OP_IMM), 64'd1, 64'd0, 64'h100_0000_0000, 1'b0);
    add_row(encode_i(12'h404, 3'd5, alu_pkg::OPC_OP_IMM), 64'hf000_0000_0000_0000, 64'd0,
            64'hff00_0000_0000_0000, 1'b0);
    add_row(encode_r(7'h00, 3'd1, alu_pkg::OPC_OP_32), 64'd1, 64'd31, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(encode_r(7'h00, 3'd5, alu_pkg::OPC_OP_32), 64'hffff_ffff_8000_0000, 64'd4,
            64'h0800_0000, 1'b0);
    add_row(encode_r(7'h20, 3'd5, alu_pkg::OPC_OP_32), 64'hffff_ffff_8000_0000, 64'd4,
            64'hffff_ffff_f800_0000, 1'b0);
    add_row(encode_r(7'h00, 3'd0, alu_pkg::OPC_OP_32), 64'h7fff_ffff, 64'd1,
            64'hffff_ffff_8000_0000, 1'b0);
    // multiply
    add_row(encode_r(7'h01, 3'd0, alu_pkg::OPC_OP), '1, '1, 64'd1, 1'b0);
    add_row(encode_r(7'h01, 3'd1, alu_pkg::OPC_OP), '1, '1, 64'd0, 1'b0);
    add_row(encode_r(7'h01, 3'd2, alu_pkg::OPC_OP), '1, '1, '1, 1'b0);
    add_row(encode_r(7'h01, 3'd3, alu_pkg::OPC_OP), '1, '1, '1 - 64'd1, 1'b0);
    add_row(encode_r(7'h01, 3'd0, alu_pkg::OPC_OP_32), 64'h1_0000, 64'h1_0000, 64'd0, 1'b0);
    // division corner cases
    add_row(encode_r(7'h01, 3'd4, alu_pkg::OPC_OP), 64'd7, 64'd0, '1, 1'b0);
    add_row(encode_r(7'h01, 3'd5, alu_pkg::OPC_OP), 64'd7, 64'd0, '1, 1'b0);
    add_row(encode_r(7'h01, 3'd6, alu_pkg::OPC_OP), 64'd7, 64'd0, 64'd7, 1'b0);
    add_row(encode_r(7'h01, 3'd7, alu_pkg::OPC_OP), 64'd7, 64'd0, 64'd7, 1'b0);
    add_row(encode_r(7'h01, 3'd4, alu_pkg::OPC_OP), 64'h8000_0000_0000_0000, '1,
            64'h8000_0000_0000_0000, 1'b0);
    add_row(encode_r(7'h01, 3'd6, alu_pkg::OPC_OP), 64'h8000_0000_0000_0000, '1, 64'd0, 1'b0);
    add_row(encode_r(7'h01, 3'd4, alu_pkg::OPC_OP), -64'sd7, 64'd2, -64'sd3, 1'b0);
    add_row(encode_r(7'h01, 3'd6, alu_pkg::OPC_OP), -64'sd7, 64'd2, '1, 1'b0);
    add_row(encode_r(7'h01, 3'd4, alu_pkg::OPC_OP_32), 64'h8000_0000, '1,
            64'hffff_ffff_8000_0000, 1'b0);
    add_row(encode_r(7'h01, 3'd6, alu_pkg::OPC_OP_32), 64'h8000_0000, '1, 64'd0, 1'b0);
    add_row(encode_r(7'h01, 3'd5, alu_pkg::OPC_OP_32), 64'd5, 64'd0, '1, 1'b0);
    add_row(encode_r(7'h01, 3'd7, alu_pkg::OPC_OP_32), 64'h1_0000_0005, 64'd0, 64'd5, 1'b0);
    // lui and an unknown funct7
    add_row({20'h80000, 5'd1, alu_pkg::OPC_LUI}, 64'd0, 64'd0, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(encode_r(7'h7f, 3'd0, alu_pkg::OPC_OP), 64'd5, 64'd7, 64'd0, 1'b1);
    // random operands, expected values from the model
    ops = '{encode_r(7'h00, 3'd0, alu_pkg::OPC_OP), encode_r(7'h20, 3'd0, alu_pkg::OPC_OP),
            encode_r(7'h01, 3'd0, alu_pkg::OPC_OP), encode_r(7'h01, 3'd1, alu_pkg::OPC_OP),
            encode_r(7'h01, 3'd2, alu_pkg::OPC_OP), encode_r(7'h01, 3'd3, alu_pkg::OPC_OP),
            encode_r(7'h01, 3'd4, alu_pkg::OPC_OP), encode_r(7'h01, 3'd5, alu_pkg::OPC_OP),
            encode_r(7'h01, 3'd6, alu_pkg::OPC_OP), encode_r(7'h01, 3'd7, alu_pkg::OPC_OP),
            encode_r(7'h20, 3'd5, alu_pkg::OPC_OP_32), encode_r(7'h01, 3'd4, alu_pkg::OPC_OP_32)};
    for (int i = 0; i < NUM_RANDOM; i++) begin
      ins = ops[i % ops.size()];
      a   = {$urandom(), $urandom()};
      b   = {$urandom(), $urandom()};
      model_result(ins, a, b, y, ill);
      add_row(ins, a, b, y, ill);
    end
  endtask

  initial begin
    i_clk      = 1'b0;
    i_reset    = 1'b1;
    i_psel     = 1'b0;
    i_penable  = 1'b0;
    i_pwrite   = 1'b0;
    i_paddr    = '0;
    i_pwdata   = '0;
    rows_ready = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    void'($urandom(84112));
    build_table();
    rows_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    foreach (rows[i]) run_row(i, rows[i]);
    check_protocol();
    $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // protocol block counts as one more row
  initial begin
    wait (rows_ready);
    repeat ((rows.size() + 1) * 40 + RESET_CYCLES) @(posedge i_clk);
    $display("timeout, the run did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

//--- alu_top.f
alu_pkg.sv
alu_apb_regs.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_top.sv
alu_top_checker.sv
alu_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the alu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f alu_top.f --top-module alu_top_tb -o alu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/alu_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
